// File: common/psx_loader_pkg.sv
// PSX loader package with download indices, RAM base addresses, widths and payload types
package psx_loader_pkg;

	// ==============================
	// Widths
	// ==============================

	localparam int ADDR_W       = 27;
	localparam int DATA_W       = 16;
	localparam int WORD_W       = 32;
	localparam int CODE_W       = 128;
	localparam int TRACK_ADDR_W = 9;

	// Number of memory card slots
	localparam int NUM_MEMCARDS = 2;

	// ==============================
	// Download indices from the host
	// ==============================

	localparam logic [7:0] IDX_BIOS   = 8'd0;
	localparam logic [7:0] IDX_EXE    = 8'd1;
	localparam logic [7:0] IDX_SBI    = 8'd250;
	localparam logic [7:0] IDX_CDINFO = 8'd251;
	localparam logic [7:0] IDX_CODE   = 8'd255;

	// ==============================
	// Main RAM byte base addresses
	// ==============================

	// BIOS image sits at 2 MB
	localparam logic [ADDR_W-1:0] BIOS_START = 27'd2097152;
	// EXE image sits at 4 MB
	localparam logic [ADDR_W-1:0] EXE_START  = 27'd4194304;

	// ==============================
	// Payload types
	// ==============================

	typedef logic [ADDR_W-1:0]       ioctl_addr_t;
	typedef logic [DATA_W-1:0]       ioctl_data_t;
	typedef logic [WORD_W-1:0]       ram_word_t;
	typedef logic [TRACK_ADDR_W-1:0] track_addr_t;

	// Flags, address, compare, replace from the top down
	typedef logic [CODE_W-1:0]       cheat_code_t;

endpackage

// File: loader/ram_word_packer.sv
// RAM word packer that pairs 16-bit download words into 32-bit RAM and track-info writes
`timescale 1ns/100ps

module ram_word_packer (
	input  logic                        clk_1x,
	input  logic                        rst,
	input  logic                        loader_busy,
	input  logic                        is_bios,
	input  logic                        is_exe,
	input  logic                        is_cdinfo,
	input  psx_loader_pkg::ioctl_addr_t ioctl_addr,
	input  psx_loader_pkg::ioctl_data_t ioctl_dout,
	input  logic                        ioctl_wr,
	input  logic                        ram_wr_ready,
	output logic                        ram_wr_valid,
	output psx_loader_pkg::ioctl_addr_t ram_wr_addr,
	output psx_loader_pkg::ram_word_t   ram_wr_data,
	output logic                        ioctl_wait,
	output logic                        track_wr,
	output psx_loader_pkg::track_addr_t track_addr,
	output psx_loader_pkg::ram_word_t   track_data
);
	import psx_loader_pkg::*;

	ioctl_addr_t base_addr;
	logic        word_lo;
	logic        word_hi;
	logic        ram_kind;
	logic        transfer;

	// ==============================
	// Word classification
	// ==============================

	// Track info is stored without a base offset
	always_comb begin
		if (is_bios) begin
			base_addr = BIOS_START;
		end else if (is_exe) begin
			base_addr = EXE_START;
		end else begin
			base_addr = '0;
		end
	end

	assign word_lo  = loader_busy & ioctl_wr & ~ioctl_addr[1];
	assign word_hi  = loader_busy & ioctl_wr & ioctl_addr[1];
	assign ram_kind = is_bios | is_exe;
	assign transfer = ram_wr_valid & ram_wr_ready;

	// ==============================
	// Pair assembly
	// ==============================

	// Low word carries the target address of the pair
	always_ff @(posedge clk_1x) begin
		if (word_lo) begin
			ram_wr_data[DATA_W-1:0] <= ioctl_dout;
			ram_wr_addr             <= ioctl_addr + base_addr;
		end
		if (word_hi) begin
			ram_wr_data[WORD_W-1:DATA_W] <= ioctl_dout;
		end
	end

	// ==============================
	// RAM handshake
	// ==============================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			ram_wr_valid <= 1'b0;
		end else if (!loader_busy) begin
			// Download gone, abandon any pending write
			ram_wr_valid <= 1'b0;
		end else if (word_hi && ram_kind) begin
			ram_wr_valid <= 1'b1;
		end else if (transfer) begin
			ram_wr_valid <= 1'b0;
		end
	end

	// Host is held off for as long as a write is outstanding
	assign ioctl_wait = ram_wr_valid & loader_busy;

	// ==============================
	// Track info path
	// ==============================

	// Single pulse per pair, never stalls the host
	always_ff @(posedge clk_1x) begin
		if (rst) begin
			track_wr <= 1'b0;
		end else begin
			track_wr <= word_hi & is_cdinfo;
		end
	end

	// Word address of the track table entry
	assign track_addr = ram_wr_addr[TRACK_ADDR_W+1:2];
	assign track_data = ram_wr_data;

endmodule

// File: loader/cheat_code_assembler.sv
// Cheat code assembler that builds 128-bit codes from eight download words
`timescale 1ns/100ps

module cheat_code_assembler (
	input  logic                        clk_1x,
	input  logic                        rst,
	input  logic                        is_code,
	input  psx_loader_pkg::ioctl_addr_t ioctl_addr,
	input  psx_loader_pkg::ioctl_data_t ioctl_dout,
	input  logic                        ioctl_wr,
	output psx_loader_pkg::cheat_code_t cheat_code,
	output logic                        code_valid,
	output logic                        cheat_clear
);

	logic is_code_d;
	logic code_wr;

	assign code_wr = is_code & ioctl_wr;

	// ==============================
	// Word placement
	// ==============================

	// Each 32-bit field arrives bottom half first
	always_ff @(posedge clk_1x) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_code[111:96]  <= ioctl_dout;
				4'd2:  cheat_code[127:112] <= ioctl_dout;
				4'd4:  cheat_code[79:64]   <= ioctl_dout;
				4'd6:  cheat_code[95:80]   <= ioctl_dout;
				4'd8:  cheat_code[47:32]   <= ioctl_dout;
				4'd10: cheat_code[63:48]   <= ioctl_dout;
				4'd12: cheat_code[15:0]    <= ioctl_dout;
				4'd14: cheat_code[31:16]   <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// ==============================
	// Pulses
	// ==============================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			is_code_d   <= 1'b0;
			cheat_clear <= 1'b0;
			code_valid  <= 1'b0;
		end else begin
			is_code_d   <= is_code;
			// New code list, drop the old one
			cheat_clear <= is_code & ~is_code_d;
			// Last word of a group completes the code
			code_valid  <= code_wr & (ioctl_addr[3:0] == 4'd14);
		end
	end

endmodule

// File: logic/download_decoder.sv
// Download decoder that flags the active download kind, latches the libcrypt key and pulses exe_load
`timescale 1ns/100ps

module download_decoder (
	input  logic                        clk_1x,
	input  logic                        rst,
	input  logic                        ioctl_download,
	input  logic [7:0]                  ioctl_index,
	input  logic                        ioctl_wr,
	input  psx_loader_pkg::ioctl_data_t ioctl_dout,
	output logic                        is_bios,
	output logic                        is_exe,
	output logic                        is_cdinfo,
	output logic                        is_code,
	output logic                        loader_busy,
	output logic                        dl_reset,
	output psx_loader_pkg::ioctl_data_t libcrypt_key,
	output logic                        exe_load
);
	import psx_loader_pkg::*;

	logic is_sbi;
	logic is_exe_d;

	// ==============================
	// Kind flags
	// ==============================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			is_bios   <= 1'b0;
			is_exe    <= 1'b0;
			is_sbi    <= 1'b0;
			is_cdinfo <= 1'b0;
			is_code   <= 1'b0;
		end else begin
			is_bios   <= ioctl_download & (ioctl_index == IDX_BIOS);
			is_exe    <= ioctl_download & (ioctl_index == IDX_EXE);
			is_sbi    <= ioctl_download & (ioctl_index == IDX_SBI);
			is_cdinfo <= ioctl_download & (ioctl_index == IDX_CDINFO);
			is_code   <= ioctl_download & (ioctl_index == IDX_CODE);
		end
	end

	// Kinds that go through the word packer
	assign loader_busy = is_bios | is_exe | is_cdinfo;

	// Console is held in reset while its memory image is replaced
	assign dl_reset = is_bios | is_exe;

	// ==============================
	// SBI key and EXE start
	// ==============================

	// Last word of the SBI download is the key
	always_ff @(posedge clk_1x) begin
		if (is_sbi && ioctl_wr) begin
			libcrypt_key <= ioctl_dout;
		end
	end

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			is_exe_d <= 1'b0;
			exe_load <= 1'b0;
		end else begin
			is_exe_d <= is_exe;
			exe_load <= is_exe_d & ~is_exe;
		end
	end

endmodule

// File: logic/memcard_command.sv
// Memory card command block that turns menu and OSD autosave edges into load and save pulses
`timescale 1ns/100ps

module memcard_command (
	input  logic clk_1x,
	input  logic rst,
	input  logic bk_load,
	input  logic bk_save,
	input  logic bk_autosave,
	input  logic osd_open,
	output logic load_all,
	output logic card_save
);

	logic autosave_req;
	logic old_load;
	logic old_save;
	logic old_autosave;

	// Autosave fires when the OSD opens with autosave on
	assign autosave_req = osd_open & bk_autosave;

	// ==============================
	// Edge detect
	// ==============================

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			old_autosave <= 1'b0;
			load_all     <= 1'b0;
			card_save    <= 1'b0;
		end else begin
			old_load     <= bk_load;
			old_save     <= bk_save;
			old_autosave <= autosave_req;
			load_all     <= bk_load & ~old_load;
			card_save    <= (bk_save & ~old_save) | (autosave_req & ~old_autosave);
		end
	end

endmodule

// File: logic/memcard_slot.sv
// Memory card slot that tracks mount state and issues card load pulses
`timescale 1ns/100ps

module memcard_slot (
	input  logic        clk_1x,
	input  logic        rst,
	input  logic        mount_event,
	input  logic [63:0] img_size,
	input  logic        load_all,
	output logic        mounted,
	output logic        card_load
);

	logic has_image;

	// Zero size means the image was unmounted
	assign has_image = |img_size;

	always_ff @(posedge clk_1x) begin
		if (rst) begin
			mounted   <= 1'b0;
			card_load <= 1'b0;
		end else begin
			if (mount_event) begin
				mounted <= has_image;
			end
			// Fresh image or a reload from the menu
			card_load <= (mount_event & has_image) | load_all;
		end
	end

endmodule

// File: logic/psx_loader.sv
// PSX loader top that decodes host downloads into RAM, track, key, cheat and memory card traffic
`timescale 1ns/100ps

module psx_loader (
	input  logic                                      clk_1x,
	input  logic                                      rst,
	input  logic                                      ioctl_download,
	input  logic [7:0]                                ioctl_index,
	input  psx_loader_pkg::ioctl_addr_t               ioctl_addr,
	input  psx_loader_pkg::ioctl_data_t               ioctl_dout,
	input  logic                                      ioctl_wr,
	input  logic                                      ram_wr_ready,
	input  logic [psx_loader_pkg::NUM_MEMCARDS-1:0]   img_mounted,
	input  logic [63:0]                               img_size,
	input  logic                                      bk_load,
	input  logic                                      bk_save,
	input  logic                                      bk_autosave,
	input  logic                                      osd_open,
	output logic                                      ioctl_wait,
	output logic                                      ram_wr_valid,
	output psx_loader_pkg::ioctl_addr_t               ram_wr_addr,
	output psx_loader_pkg::ram_word_t                 ram_wr_data,
	output logic                                      track_wr,
	output psx_loader_pkg::track_addr_t               track_addr,
	output psx_loader_pkg::ram_word_t                 track_data,
	output psx_loader_pkg::ioctl_data_t               libcrypt_key,
	output logic                                      exe_load,
	output logic                                      dl_reset,
	output psx_loader_pkg::cheat_code_t               cheat_code,
	output logic                                      code_valid,
	output logic                                      cheat_clear,
	output logic [psx_loader_pkg::NUM_MEMCARDS-1:0]   card_load,
	output logic [psx_loader_pkg::NUM_MEMCARDS-1:0]   card_mounted,
	output logic                                      card_save
);
	import psx_loader_pkg::*;

	logic is_bios;
	logic is_exe;
	logic is_cdinfo;
	logic is_code;
	logic loader_busy;
	logic load_all;

	// ==============================
	// Download front end
	// ==============================

	download_decoder u_decoder (
		.clk_1x         (clk_1x),
		.rst            (rst),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_dout     (ioctl_dout),
		.is_bios        (is_bios),
		.is_exe         (is_exe),
		.is_cdinfo      (is_cdinfo),
		.is_code        (is_code),
		.loader_busy    (loader_busy),
		.dl_reset       (dl_reset),
		.libcrypt_key   (libcrypt_key),
		.exe_load       (exe_load)
	);

	ram_word_packer u_packer (
		.clk_1x       (clk_1x),
		.rst          (rst),
		.loader_busy  (loader_busy),
		.is_bios      (is_bios),
		.is_exe       (is_exe),
		.is_cdinfo    (is_cdinfo),
		.ioctl_addr   (ioctl_addr),
		.ioctl_dout   (ioctl_dout),
		.ioctl_wr     (ioctl_wr),
		.ram_wr_ready (ram_wr_ready),
		.ram_wr_valid (ram_wr_valid),
		.ram_wr_addr  (ram_wr_addr),
		.ram_wr_data  (ram_wr_data),
		.ioctl_wait   (ioctl_wait),
		.track_wr     (track_wr),
		.track_addr   (track_addr),
		.track_data   (track_data)
	);

	cheat_code_assembler u_cheats (
		.clk_1x      (clk_1x),
		.rst         (rst),
		.is_code     (is_code),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.ioctl_wr    (ioctl_wr),
		.cheat_code  (cheat_code),
		.code_valid  (code_valid),
		.cheat_clear (cheat_clear)
	);

	// ==============================
	// Memory cards
	// ==============================

	memcard_command u_memcard_cmd (
		.clk_1x      (clk_1x),
		.rst         (rst),
		.bk_load     (bk_load),
		.bk_save     (bk_save),
		.bk_autosave (bk_autosave),
		.osd_open    (osd_open),
		.load_all    (load_all),
		.card_save   (card_save)
	);

	// One slot per card, all share the broadcast reload
	for (genvar i = 0; i < NUM_MEMCARDS; i++) begin : g_slot
		memcard_slot u_slot (
			.clk_1x      (clk_1x),
			.rst         (rst),
			.mount_event (img_mounted[i]),
			.img_size    (img_size),
			.load_all    (load_all),
			.mounted     (card_mounted[i]),
			.card_load   (card_load[i])
		);
	end

endmodule

// File: dv/tb_clock.sv
// Testbench clock and reset generator for the PSX loader
`timescale 1ns/100ps

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_1x,
	output logic rst
);

	initial begin
		clk_1x = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clk_1x = ~clk_1x;
		end
	end

	// Reset drops on a falling edge, away from the sampling edge
	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(negedge clk_1x);
		rst = 1'b0;
	end

endmodule

// File: dv/tb_psx_loader.sv
// Testbench for the PSX loader covering downloads, track info, cheats and memory cards
`timescale 1ns/100ps

module tb_psx_loader;
	import psx_loader_pkg::*;

	localparam int CLK_PERIOD_NS = 40;
	localparam int RESET_CYCLES  = 10;
	localparam int RAM_PAIRS     = 8;
	localparam int WAIT_LIMIT    = 64;
	localparam logic [31:0] SEED = 32'd40985;

	// Cycle budget of each test, summed for the watchdog
	localparam int TEST_CYCLES = 2 * RESET_CYCLES + 2 * (RAM_PAIRS * 24 + 20) + 60 + 40 + 100 + 80;
	localparam int MARGIN      = 4;
	localparam int WATCHDOG_NS = TEST_CYCLES * MARGIN * CLK_PERIOD_NS;

	logic clk_1x;
	logic rst;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	ioctl_addr_t ioctl_addr;
	ioctl_data_t ioctl_dout;
	logic ioctl_wr;
	logic ram_wr_ready;
	logic [NUM_MEMCARDS-1:0] img_mounted;
	logic [63:0] img_size;
	logic bk_load;
	logic bk_save;
	logic bk_autosave;
	logic osd_open;
	logic ioctl_wait;
	logic ram_wr_valid;
	ioctl_addr_t ram_wr_addr;
	ram_word_t ram_wr_data;
	logic track_wr;
	track_addr_t track_addr;
	ram_word_t track_data;
	ioctl_data_t libcrypt_key;
	logic exe_load;
	logic dl_reset;
	cheat_code_t cheat_code;
	logic code_valid;
	logic cheat_clear;
	logic [NUM_MEMCARDS-1:0] card_load;
	logic [NUM_MEMCARDS-1:0] card_mounted;
	logic card_save;

	// Scoreboard queues and pulse counters
	ioctl_addr_t ram_addr_q[$];
	ram_word_t ram_data_q[$];
	track_addr_t track_addr_q[$];
	ram_word_t track_data_q[$];
	cheat_code_t code_q[$];
	int exe_count;
	int clear_count;
	int valid_count;
	int save_count;
	int load_count [NUM_MEMCARDS];
	int value_errors = 0;
	int protocol_errors = 0;
	string test_name = "startup";
	logic cdinfo_active = 1'b0;
	logic [31:0] lcg_state = SEED;

	// Monitor state from the previous sampling edge
	logic held_valid = 1'b0;
	ioctl_addr_t held_addr;
	ram_word_t held_data;
	logic [NUM_MEMCARDS+4:0] pulses;
	logic [NUM_MEMCARDS+4:0] prev_pulses = '0;

	assign pulses = {card_load, track_wr, exe_load, code_valid, cheat_clear, card_save};

	tb_clock #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
		.clk_1x (clk_1x),
		.rst    (rst)
	);

	psx_loader u_dut (
		.clk_1x (clk_1x), .rst (rst),
		.ioctl_download (ioctl_download), .ioctl_index (ioctl_index),
		.ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout), .ioctl_wr (ioctl_wr),
		.ram_wr_ready (ram_wr_ready), .img_mounted (img_mounted), .img_size (img_size),
		.bk_load (bk_load), .bk_save (bk_save), .bk_autosave (bk_autosave),
		.osd_open (osd_open), .ioctl_wait (ioctl_wait), .ram_wr_valid (ram_wr_valid),
		.ram_wr_addr (ram_wr_addr), .ram_wr_data (ram_wr_data), .track_wr (track_wr),
		.track_addr (track_addr), .track_data (track_data), .libcrypt_key (libcrypt_key),
		.exe_load (exe_load), .dl_reset (dl_reset), .cheat_code (cheat_code),
		.code_valid (code_valid), .cheat_clear (cheat_clear), .card_load (card_load),
		.card_mounted (card_mounted), .card_save (card_save)
	);

	// ==============================
	// Checking helpers
	// ==============================

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_value(input string what, input logic [127:0] exp, input logic [127:0] act);
		assert (act === exp)
		else begin
			value_errors++;
			$display("ERROR %s %s: expected %0h, actual %0h", test_name, what, exp, act);
		end
	endtask

	task automatic report_failure(input string what);
		protocol_errors++;
		$display("FAILURE in %s: %s", test_name, what);
	endtask

	task automatic check_drained();
		assert (ram_addr_q.size() == 0 && track_addr_q.size() == 0 && code_q.size() == 0)
		else report_failure("some expected RAM, track or cheat writes never appeared");
	endtask

	task automatic clear_counts();
		exe_count = 0;
		clear_count = 0;
		valid_count = 0;
		save_count = 0;
		for (int i = 0; i < NUM_MEMCARDS; i++) begin
			load_count[i] = 0;
		end
	endtask

	// ==============================
	// Host download driver
	// ==============================

	task automatic wait_for_idle();
		int n;
		n = 0;
		while (ioctl_wait && n < WAIT_LIMIT) begin
			@(negedge clk_1x);
			n++;
		end
		if (ioctl_wait) begin
			report_failure("ioctl_wait stuck high, RAM write never accepted");
		end
	endtask

	task automatic host_write(input ioctl_addr_t addr, input ioctl_data_t data);
		wait_for_idle();
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		@(negedge clk_1x);
		ioctl_wr = 1'b0;
	endtask

	task automatic start_download(input logic [7:0] index);
		ioctl_index = index;
		ioctl_download = 1'b1;
		repeat (2) @(negedge clk_1x);
	endtask

	task automatic finish_download();
		wait_for_idle();
		repeat (2) @(negedge clk_1x);
		ioctl_download = 1'b0;
		repeat (3) @(negedge clk_1x);
	endtask

	task automatic run_ram_download(input logic [7:0] index, input ioctl_addr_t base);
		ioctl_addr_t a;
		ioctl_data_t lo;
		ioctl_data_t hi;
		start_download(index);
		check_value("dl_reset at start", 1, dl_reset);
		for (int p = 0; p < RAM_PAIRS; p++) begin
			a = 27'h200 + 27'(p * 4);
			lo = {8'(p), 8'h5a} ^ {index, index};
			hi = ~lo + 16'(index);
			ram_addr_q.push_back(a + base);
			ram_data_q.push_back({hi, lo});
			host_write(a, lo);
			host_write(a + 27'd2, hi);
		end
		check_value("dl_reset at end", 1, dl_reset);
		check_value("exe_load before download end", 0, exe_count);
		finish_download();
		check_drained();
	endtask

	task automatic run_track_download();
		ioctl_addr_t a;
		ioctl_data_t lo;
		ioctl_data_t hi;
		cdinfo_active = 1'b1;
		start_download(IDX_CDINFO);
		for (int p = 0; p < 6; p++) begin
			a = 27'h040 + 27'(p * 4);
			lo = 16'h7100 + 16'(p);
			hi = 16'he200 - 16'(p * 3);
			track_addr_q.push_back(a[10:2]);
			track_data_q.push_back({hi, lo});
			host_write(a, lo);
			host_write(a + 27'd2, hi);
		end
		finish_download();
		cdinfo_active = 1'b0;
		check_drained();
	endtask

	task automatic run_cheat_download(input int codes);
		ioctl_data_t w [8];
		start_download(IDX_CODE);
		check_value("cheat_clear after start", 1, cheat_clear);
		for (int c = 0; c < codes; c++) begin
			for (int k = 0; k < 8; k++) begin
				w[k] = 16'hc000 ^ 16'(c * 16 + k * 257);
			end
			// Each 32-bit field takes its high half from the word at offset plus 2
			code_q.push_back({w[1], w[0], w[3], w[2], w[5], w[4], w[7], w[6]});
			for (int k = 0; k < 8; k++) begin
				host_write(27'(c * 16 + k * 2), w[k]);
			end
		end
		finish_download();
	endtask

	task automatic mount_image(input int slot, input logic [63:0] size);
		img_size = size;
		img_mounted[slot] = 1'b1;
		@(negedge clk_1x);
		img_mounted = '0;
		repeat (3) @(negedge clk_1x);
	endtask

	// ==============================
	// RAM ready model
	// ==============================

	always @(negedge clk_1x) begin
		lcg_state = lcg_next(lcg_state);
		ram_wr_ready = (lcg_state[18:16] < 3'd3);
	end

	// ==============================
	// Monitors and scoreboard
	// ==============================

	always @(posedge clk_1x) begin
		if (!rst) begin
			if (held_valid) begin
				assert (ram_wr_valid && ram_wr_addr === held_addr && ram_wr_data === held_data)
				else report_failure("RAM write dropped or changed while ready was low");
			end
			if (dl_reset) begin
				assert (ioctl_wait === ram_wr_valid)
				else report_failure("ioctl_wait does not cover the pending RAM write");
			end
			if (cdinfo_active) begin
				assert (!ioctl_wait && !ram_wr_valid)
				else report_failure("track info download stalled the host or wrote RAM");
			end
			assert ((pulses & prev_pulses) == '0)
			else report_failure("a pulse output stayed high for more than one cycle");
			if (ram_wr_valid && ram_wr_ready) begin
				if (ram_addr_q.size() == 0) begin
					report_failure("RAM write with no write expected");
				end else begin
					check_value("RAM address", ram_addr_q.pop_front(), ram_wr_addr);
					check_value("RAM data", ram_data_q.pop_front(), ram_wr_data);
				end
			end
			if (track_wr) begin
				if (track_addr_q.size() == 0) begin
					report_failure("track write with no write expected");
				end else begin
					check_value("track address", track_addr_q.pop_front(), track_addr);
					check_value("track data", track_data_q.pop_front(), track_data);
				end
			end
			if (code_valid) begin
				if (code_q.size() == 0) begin
					report_failure("cheat code valid with no code expected");
				end else begin
					check_value("cheat code", code_q.pop_front(), cheat_code);
				end
			end
			exe_count += exe_load;
			clear_count += cheat_clear;
			valid_count += code_valid;
			save_count += card_save;
			for (int i = 0; i < NUM_MEMCARDS; i++) begin
				load_count[i] += card_load[i];
			end
			held_valid = ram_wr_valid & ~ram_wr_ready;
			held_addr = ram_wr_addr;
			held_data = ram_wr_data;
			prev_pulses = pulses;
		end
	end

	// Watchdog
	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("CHECKS FAILED");
		$finish;
	end

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		ram_wr_ready = 1'b0;
		img_mounted = '0;
		img_size = '0;
		bk_load = 1'b0;
		bk_save = 1'b0;
		bk_autosave = 1'b0;
		osd_open = 1'b0;
		clear_counts();
		do @(negedge clk_1x); while (rst);
		@(negedge clk_1x);

		test_name = "reset";
		check_value("control outputs", '0, {ram_wr_valid, ioctl_wait, track_wr, code_valid,
			cheat_clear, exe_load, card_save, card_load, card_mounted, dl_reset});

		test_name = "bios";
		run_ram_download(IDX_BIOS, BIOS_START);
		check_value("exe_load pulses", 0, exe_count);
		test_name = "exe";
		clear_counts();
		run_ram_download(IDX_EXE, EXE_START);
		repeat (4) @(negedge clk_1x);
		check_value("exe_load pulses", 1, exe_count);

		test_name = "cdinfo";
		run_track_download();

		test_name = "sbi";
		start_download(IDX_SBI);
		host_write(27'd0, 16'h1234);
		host_write(27'd2, 16'h8e71);
		host_write(27'd4, 16'hc3a5);
		finish_download();
		check_value("libcrypt_key", 16'hc3a5, libcrypt_key);

		test_name = "cheats";
		clear_counts();
		run_cheat_download(2);
		run_cheat_download(1);
		check_value("cheat_clear pulses", 2, clear_count);
		check_value("code_valid pulses", 3, valid_count);
		check_drained();

		test_name = "memcard";
		clear_counts();
		mount_image(0, 64'd131072);
		check_value("mounted after slot 0 mount", 2'b01, card_mounted);
		check_value("slot 0 loads", 1, load_count[0]);
		check_value("slot 1 loads", 0, load_count[1]);
		mount_image(1, 64'd131072);
		check_value("mounted after slot 1 mount", 2'b11, card_mounted);
		check_value("slot 1 loads", 1, load_count[1]);
		mount_image(0, 64'd0);
		check_value("mounted after slot 0 unmount", 2'b10, card_mounted);
		check_value("slot 0 loads after unmount", 1, load_count[0]);

		// Held levels must not repeat a pulse
		clear_counts();
		bk_load = 1'b1;
		repeat (6) @(negedge clk_1x);
		bk_load = 1'b0;
		repeat (2) @(negedge clk_1x);
		check_value("slot 0 menu loads", 1, load_count[0]);
		check_value("slot 1 menu loads", 1, load_count[1]);
		bk_save = 1'b1;
		repeat (6) @(negedge clk_1x);
		check_value("card_save pulses after bk_save", 1, save_count);
		bk_save = 1'b0;
		osd_open = 1'b1;
		repeat (4) @(negedge clk_1x);
		check_value("card_save pulses without autosave", 1, save_count);
		osd_open = 1'b0;
		bk_autosave = 1'b1;
		repeat (2) @(negedge clk_1x);
		osd_open = 1'b1;
		repeat (6) @(negedge clk_1x);
		osd_open = 1'b0;
		bk_autosave = 1'b0;
		repeat (2) @(negedge clk_1x);
		check_value("card_save pulses", 2, save_count);

		$display("Summary: %0d value errors, %0d protocol errors", value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
common/psx_loader_pkg.sv
loader/ram_word_packer.sv
loader/cheat_code_assembler.sv
logic/download_decoder.sv
logic/memcard_command.sv
logic/memcard_slot.sv
logic/psx_loader.sv
dv/tb_clock.sv
dv/tb_psx_loader.sv
